/* logic/hpsdr_pkg.sv */
// shared definitions for the downstream control path
//   protocol-1 framing constants
//   decoded command addresses
//   command and radio config structs
//   state enums of the parser and the T/R sequencer

`default_nettype none

package hpsdr_pkg;

  ////////////////////
  // protocol-1 framing

  localparam logic [7:0] SYNC_BYTE     = 8'h7F;
  localparam logic [7:0] HDR_BYTE0     = 8'hEF;
  localparam logic [7:0] HDR_BYTE1     = 8'hFE;
  localparam logic [7:0] PKT_DATA      = 8'h01;
  localparam logic [7:0] PKT_STARTSTOP = 8'h04;

  localparam int FRAME_BYTES    = 512;
  localparam int FRAMES_PER_PKT = 2;
  // preamble, type, endpoint, 4 sequence bytes
  localparam int DATA_HDR_BYTES = 8;

  // command addresses with a decoded meaning
  localparam logic [5:0] ADDR_CONFIG   = 6'd0;
  localparam logic [5:0] ADDR_TX_DRIVE = 6'd9;

  ////////////////////
  // types

  // one command from C0..C4 of a frame
  typedef struct packed {
    logic [5:0]  addr;
    logic        mox;
    logic [31:0] data;
  } cmd_t;

  typedef enum logic [1:0] {
    RATE_48K,
    RATE_96K,
    RATE_192K,
    RATE_384K
  } rate_e;

  typedef struct packed {
    rate_e       rate;
    logic [3:0]  num_rx;
    logic [7:0]  tx_drive;
    logic        mox;
  } radio_cfg_t;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    STARTSTOP,
    FRAME_SYNC,
    CTRL,
    PAYLOAD,
    DISCARD
  } parse_state_e;

  typedef enum logic [1:0] {
    RX,
    SWITCHING,
    TX,
    HANG
  } tr_state_e;

endpackage

`default_nettype wire

/* logic/ds_packet_parser.sv */
// protocol-1 downstream packet parser
//   port and preamble check
//   start/stop decode into run and wide spectrum
//   frame sync check, command extraction, sync error count

`timescale 1ns/10ps
`default_nettype none

module ds_packet_parser #(
  parameter logic [15:0] DATA_PORT = 16'd1024
) (
  input  wire logic              clk_ctrl,
  input  wire logic              rst_i,
  input  wire logic              eth_valid_i,
  input  wire logic [7:0]        eth_data_i,
  input  wire logic [15:0]       eth_port_i,
  output hpsdr_pkg::cmd_t        cmd_o,
  output logic                   cmd_valid_o,
  output logic                   run_o,
  output logic                   wide_spectrum_o,
  output logic [7:0]             sync_errors_o
);

  // 3 sync bytes and 5 control bytes lead each frame
  localparam int PAYLOAD_BYTES = hpsdr_pkg::FRAME_BYTES - 8;
  localparam int FRAME_CNT_W   = $clog2(hpsdr_pkg::FRAMES_PER_PKT + 1);

  hpsdr_pkg::parse_state_e state;
  logic [9:0]              byte_cnt;
  logic [FRAME_CNT_W-1:0]  frame_cnt;
  logic                    sync_ok;
  logic                    sync_all;
  logic [6:0]              c0_q;
  logic [23:0]             data_sr;

  // running result of the sync check including the current byte
  assign sync_all = (byte_cnt == 10'd0 || sync_ok) && (eth_data_i == hpsdr_pkg::SYNC_BYTE);

  ////////////////////
  // control FSM

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state           <= hpsdr_pkg::IDLE;
      byte_cnt        <= '0;
      frame_cnt       <= '0;
      sync_ok         <= 1'b0;
      cmd_valid_o     <= 1'b0;
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      sync_errors_o   <= '0;
    end else begin
      cmd_valid_o <= 1'b0;
      if (!eth_valid_i) begin
        // gap between packets
        state <= hpsdr_pkg::IDLE;
      end else begin
        byte_cnt <= byte_cnt + 10'd1;
        case (state)
          hpsdr_pkg::IDLE: begin
            byte_cnt  <= 10'd1;
            frame_cnt <= '0;
            if (eth_port_i == DATA_PORT && eth_data_i == hpsdr_pkg::HDR_BYTE0) begin
              state <= hpsdr_pkg::HEADER;
            end else begin
              state <= hpsdr_pkg::DISCARD;
            end
          end
          hpsdr_pkg::HEADER: begin
            if (byte_cnt == 10'd1) begin
              if (eth_data_i != hpsdr_pkg::HDR_BYTE1) begin
                state <= hpsdr_pkg::DISCARD;
              end
            end else if (byte_cnt == 10'd2) begin
              // packet type, data packets stay here for endpoint and sequence
              if (eth_data_i == hpsdr_pkg::PKT_STARTSTOP) begin
                state <= hpsdr_pkg::STARTSTOP;
              end else if (eth_data_i != hpsdr_pkg::PKT_DATA) begin
                state <= hpsdr_pkg::DISCARD;
              end
            end else if (byte_cnt == 10'(hpsdr_pkg::DATA_HDR_BYTES - 1)) begin
              byte_cnt <= '0;
              state    <= hpsdr_pkg::FRAME_SYNC;
            end
          end
          hpsdr_pkg::STARTSTOP: begin
            run_o           <= eth_data_i[0];
            wide_spectrum_o <= eth_data_i[1];
            state           <= hpsdr_pkg::DISCARD;
          end
          hpsdr_pkg::FRAME_SYNC: begin
            sync_ok <= sync_all;
            if (byte_cnt == 10'd2) begin
              byte_cnt <= '0;
              state    <= hpsdr_pkg::CTRL;
              if (!sync_all && sync_errors_o != 8'hFF) begin
                sync_errors_o <= sync_errors_o + 8'd1;
              end
            end
          end
          hpsdr_pkg::CTRL: begin
            if (byte_cnt == 10'd4) begin
              // bad sync suppresses the command of this frame
              cmd_valid_o <= sync_ok;
              byte_cnt    <= '0;
              state       <= hpsdr_pkg::PAYLOAD;
            end
          end
          hpsdr_pkg::PAYLOAD: begin
            if (byte_cnt == 10'(PAYLOAD_BYTES - 1)) begin
              byte_cnt <= '0;
              if (frame_cnt == FRAME_CNT_W'(hpsdr_pkg::FRAMES_PER_PKT - 1)) begin
                state <= hpsdr_pkg::DISCARD;
              end else begin
                frame_cnt <= frame_cnt + 1'b1;
                state     <= hpsdr_pkg::FRAME_SYNC;
              end
            end
          end
          default: begin
            // drop bytes until the packet ends
            state <= hpsdr_pkg::DISCARD;
          end
        endcase
      end
    end
  end

  ////////////////////
  // command assembly

  always_ff @(posedge clk_ctrl) begin
    if (eth_valid_i && state == hpsdr_pkg::CTRL) begin
      case (byte_cnt)
        10'd0: begin
          c0_q <= eth_data_i[6:0];
        end
        10'd4: begin
          cmd_o.addr <= c0_q[6:1];
          cmd_o.mox  <= c0_q[0];
          cmd_o.data <= {data_sr, eth_data_i};
        end
        default: begin
          // C1..C3, C1 ends up most significant
          data_sr <= {data_sr[15:0], eth_data_i};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_regs.sv */
// command register bank
//   64 x 32 storage written by parsed commands
//   sample rate, receiver count and drive decode
//   registered readback port

`timescale 1ns/10ps
`default_nettype none

module cmd_regs (
  input  wire logic              clk_ctrl,
  input  wire logic              rst_i,
  input  wire hpsdr_pkg::cmd_t   cmd_i,
  input  wire logic              cmd_valid_i,
  input  wire logic [5:0]        rd_addr_i,
  output hpsdr_pkg::radio_cfg_t  cfg_o,
  output logic [31:0]            rd_data_o
);

  logic [31:0] regs_q [64];
  // addresses written since reset, others read as zero
  logic [63:0] written_q;
  logic        mox_q;
  logic [31:0] cfg_word;
  logic [31:0] drive_word;

  ////////////////////
  // storage

  always_ff @(posedge clk_ctrl) begin
    if (cmd_valid_i) begin
      regs_q[cmd_i.addr] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      written_q <= '0;
      mox_q     <= 1'b0;
      rd_data_o <= '0;
    end else begin
      if (cmd_valid_i) begin
        written_q[cmd_i.addr] <= 1'b1;
        // mox rides on every command
        mox_q <= cmd_i.mox;
      end
      rd_data_o <= written_q[rd_addr_i] ? regs_q[rd_addr_i] : 32'd0;
    end
  end

  ////////////////////
  // config decode

  assign cfg_word   = written_q[hpsdr_pkg::ADDR_CONFIG] ?
                      regs_q[hpsdr_pkg::ADDR_CONFIG] : 32'd0;
  assign drive_word = written_q[hpsdr_pkg::ADDR_TX_DRIVE] ?
                      regs_q[hpsdr_pkg::ADDR_TX_DRIVE] : 32'd0;

  always_comb begin
    cfg_o.rate     = hpsdr_pkg::rate_e'(cfg_word[25:24]);
    // field holds receivers minus one
    cfg_o.num_rx   = cfg_word[6:3] + 4'd1;
    cfg_o.tx_drive = drive_word[31:24];
    cfg_o.mox      = mox_q;
  end

endmodule

`default_nettype wire

/* logic/tr_sequencer.sv */
// transmit/receive sequencer
//   PA T/R relay keying with settle delay before TX enable
//   hang time before the relay drops
//   run and TX LEDs

`timescale 1ns/10ps
`default_nettype none

module tr_sequencer #(
  parameter int TR_DELAY = 20,
  parameter int TR_HANG  = 10
) (
  input  wire logic clk_ctrl,
  input  wire logic rst_i,
  input  wire logic mox_i,
  input  wire logic run_i,
  input  wire logic tx_inhibit_i,
  output logic      pa_tr_o,
  output logic      tx_en_o,
  output logic      led_run_o,
  output logic      led_tx_o
);

  localparam int CNT_MAX = (TR_DELAY > TR_HANG) ? TR_DELAY : TR_HANG;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  hpsdr_pkg::tr_state_e state;
  logic [CNT_W-1:0]     cnt;
  logic                 tx_req;

  assign tx_req = mox_i && run_i && !tx_inhibit_i;

  ////////////////////
  // T/R FSM

  // one counter serves both the settle delay and the hang time
  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state <= hpsdr_pkg::RX;
      cnt   <= '0;
    end else begin
      case (state)
        hpsdr_pkg::RX: begin
          if (tx_req) begin
            cnt   <= CNT_W'(TR_DELAY - 1);
            state <= hpsdr_pkg::SWITCHING;
          end
        end
        hpsdr_pkg::SWITCHING: begin
          // no RF yet, so the relay may drop at once
          if (!tx_req) begin
            state <= hpsdr_pkg::RX;
          end else if (cnt == '0) begin
            state <= hpsdr_pkg::TX;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        hpsdr_pkg::TX: begin
          if (!tx_req) begin
            cnt   <= CNT_W'(TR_HANG - 1);
            state <= hpsdr_pkg::HANG;
          end
        end
        hpsdr_pkg::HANG: begin
          // relay still keyed, rekey without a new settle delay
          if (tx_req) begin
            state <= hpsdr_pkg::TX;
          end else if (cnt == '0) begin
            state <= hpsdr_pkg::RX;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= hpsdr_pkg::RX;
        end
      endcase
    end
  end

  ////////////////////
  // outputs

  assign pa_tr_o   = (state != hpsdr_pkg::RX);
  assign tx_en_o   = (state == hpsdr_pkg::TX);
  assign led_run_o = run_i;
  assign led_tx_o  = tx_en_o;

endmodule

`default_nettype wire

/* logic/hpsdr_ds_ctrl.sv */
// downstream control path top level
//   packet parser, command register bank, T/R sequencer

`timescale 1ns/10ps
`default_nettype none

module hpsdr_ds_ctrl #(
  parameter logic [15:0] DATA_PORT = 16'd1024,
  parameter int          TR_DELAY  = 20,
  parameter int          TR_HANG   = 10
) (
  input  wire logic              clk_ctrl,
  input  wire logic              rst_i,
  input  wire logic              eth_valid_i,
  input  wire logic [7:0]        eth_data_i,
  input  wire logic [15:0]       eth_port_i,
  input  wire logic              tx_inhibit_i,
  input  wire logic [5:0]        rd_addr_i,
  output hpsdr_pkg::radio_cfg_t  cfg_o,
  output logic [31:0]            rd_data_o,
  output logic                   run_o,
  output logic                   wide_spectrum_o,
  output logic [7:0]             sync_errors_o,
  output logic                   pa_tr_o,
  output logic                   tx_en_o,
  output logic                   led_run_o,
  output logic                   led_tx_o
);

  hpsdr_pkg::cmd_t cmd;
  logic            cmd_valid;

  ds_packet_parser #(
    .DATA_PORT(DATA_PORT)
  ) u_parser (
    .clk_ctrl       (clk_ctrl),
    .rst_i          (rst_i),
    .eth_valid_i    (eth_valid_i),
    .eth_data_i     (eth_data_i),
    .eth_port_i     (eth_port_i),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .run_o          (run_o),
    .wide_spectrum_o(wide_spectrum_o),
    .sync_errors_o  (sync_errors_o)
  );

  cmd_regs u_cmd_regs (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .cmd_i      (cmd),
    .cmd_valid_i(cmd_valid),
    .rd_addr_i  (rd_addr_i),
    .cfg_o      (cfg_o),
    .rd_data_o  (rd_data_o)
  );

  // only mox of the config reaches the sequencer
  tr_sequencer #(
    .TR_DELAY(TR_DELAY),
    .TR_HANG (TR_HANG)
  ) u_tr_seq (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .mox_i       (cfg_o.mox),
    .run_i       (run_o),
    .tx_inhibit_i(tx_inhibit_i),
    .pa_tr_o     (pa_tr_o),
    .tx_en_o     (tx_en_o),
    .led_run_o   (led_run_o),
    .led_tx_o    (led_tx_o)
  );

endmodule

`default_nettype wire

/* tb/tb_packets.svh */
// packet builders for the downstream parser
//   byte driver and packet gap
//   start/stop packet
//   data packet with two frames of commands and random payload

`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

// one byte per cycle, entered and left on a falling edge
task automatic drive_byte(input logic [15:0] port, input logic [7:0] value);
  eth_port_i  = port;
  eth_valid_i = 1'b1;
  eth_data_i  = value;
  @(negedge clk_ctrl);
endtask

task automatic end_packet();
  eth_valid_i = 1'b0;
  eth_data_i  = 8'h00;
  repeat (2) @(negedge clk_ctrl);
endtask

// ctrl bit 0 is run, bit 1 wide spectrum
task automatic send_startstop(input logic [15:0] port, input logic [7:0] ctrl);
  drive_byte(port, hpsdr_pkg::HDR_BYTE0);
  drive_byte(port, hpsdr_pkg::HDR_BYTE1);
  drive_byte(port, hpsdr_pkg::PKT_STARTSTOP);
  ss_ctrl_cyc = cyc;
  drive_byte(port, ctrl);
  // pad to the usual 64 byte length
  repeat (60) drive_byte(port, 8'h00);
  end_packet();
endtask

// bad_frame picks a frame whose second sync byte is corrupted, -1 for none
task automatic send_data_pkt(
  input logic [15:0]     port,
  input logic [7:0]      preamble0,
  input hpsdr_pkg::cmd_t cmd0,
  input hpsdr_pkg::cmd_t cmd1,
  input int              bad_frame
);
  hpsdr_pkg::cmd_t c;
  logic [7:0]      sync;
  drive_byte(port, preamble0);
  drive_byte(port, hpsdr_pkg::HDR_BYTE1);
  drive_byte(port, hpsdr_pkg::PKT_DATA);
  // endpoint 2 carries commands and TX samples
  drive_byte(port, 8'h02);
  for (int i = 3; i >= 0; i--) begin
    drive_byte(port, seq_num[8*i +: 8]);
  end
  seq_num++;
  for (int f = 0; f < hpsdr_pkg::FRAMES_PER_PKT; f++) begin
    c = (f == 0) ? cmd0 : cmd1;
    for (int s = 0; s < 3; s++) begin
      sync = (f == bad_frame && s == 1) ? 8'h7E : hpsdr_pkg::SYNC_BYTE;
      drive_byte(port, sync);
    end
    drive_byte(port, {1'b0, c.addr, c.mox});
    drive_byte(port, c.data[31:24]);
    drive_byte(port, c.data[23:16]);
    drive_byte(port, c.data[15:8]);
    c4_cyc[f] = cyc;
    drive_byte(port, c.data[7:0]);
    // sample payload, only counted past
    repeat (hpsdr_pkg::FRAME_BYTES - 8) drive_byte(port, 8'($urandom));
  end
  end_packet();
endtask

`endif

/* tb/tb_hpsdr_ds_ctrl.sv */
// testbench for the downstream control path
//   clock, reset and DUT
//   edge timestamps and property checks on the T/R outputs
//   register bank model and readback checks
//   watchdog and test sequence

`timescale 1ns/10ps
`default_nettype none

module tb_hpsdr_ds_ctrl;

  localparam logic [15:0] DATA_PORT       = 16'd1024;
  localparam int          TR_DELAY        = 20;
  localparam int          TR_HANG         = 10;
  localparam int          NUM_PKTS        = 14;
  localparam int          WATCHDOG_CYCLES = NUM_PKTS * 1100 + 2000;

  logic                  clk_ctrl;
  logic                  rst_i;
  logic                  eth_valid_i;
  logic [7:0]            eth_data_i;
  logic [15:0]           eth_port_i;
  logic                  tx_inhibit_i;
  logic [5:0]            rd_addr_i;
  hpsdr_pkg::radio_cfg_t cfg_o;
  logic [31:0]           rd_data_o;
  logic                  run_o;
  logic                  wide_spectrum_o;
  logic [7:0]            sync_errors_o;
  logic                  pa_tr_o;
  logic                  tx_en_o;
  logic                  led_run_o;
  logic                  led_tx_o;

  // cycle count and edge timestamps taken on falling edges
  int          cyc = 0;
  int          c4_cyc [2];
  int          ss_ctrl_cyc = -1;
  int          run_rise_cyc = -1;
  int          pa_rise_cyc = -1;
  int          pa_fall_cyc = -1;
  int          tx_rise_cyc = -1;
  int          tx_fall_cyc = -1;
  int          pa_rises = 0;
  logic        pa_q = 1'b0;
  logic        tx_q = 1'b0;
  logic        run_q = 1'b0;
  logic [31:0] seq_num = '0;
  logic [31:0] exp_regs [64];
  int          checks = 0;
  int          errors = 0;

  hpsdr_ds_ctrl #(
    .DATA_PORT(DATA_PORT),
    .TR_DELAY (TR_DELAY),
    .TR_HANG  (TR_HANG)
  ) DUT (
    .clk_ctrl       (clk_ctrl),
    .rst_i          (rst_i),
    .eth_valid_i    (eth_valid_i),
    .eth_data_i     (eth_data_i),
    .eth_port_i     (eth_port_i),
    .tx_inhibit_i   (tx_inhibit_i),
    .rd_addr_i      (rd_addr_i),
    .cfg_o          (cfg_o),
    .rd_data_o      (rd_data_o),
    .run_o          (run_o),
    .wide_spectrum_o(wide_spectrum_o),
    .sync_errors_o  (sync_errors_o),
    .pa_tr_o        (pa_tr_o),
    .tx_en_o        (tx_en_o),
    .led_run_o      (led_run_o),
    .led_tx_o       (led_tx_o)
  );

  `include "tb_packets.svh"

  initial begin
    clk_ctrl = 1'b0;
    forever #5 clk_ctrl = ~clk_ctrl;
  end

  always @(posedge clk_ctrl) begin
    cyc <= cyc + 1;
  end

  always @(negedge clk_ctrl) begin
    if (pa_tr_o && !pa_q) begin
      pa_rise_cyc = cyc;
      pa_rises++;
    end
    if (!pa_tr_o && pa_q) pa_fall_cyc = cyc;
    if (tx_en_o && !tx_q) tx_rise_cyc = cyc;
    if (!tx_en_o && tx_q) tx_fall_cyc = cyc;
    if (run_o && !run_q) run_rise_cyc = cyc;
    pa_q  = pa_tr_o;
    tx_q  = tx_en_o;
    run_q = run_o;
  end

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  ////////////////////
  // properties

  led_tx_follows: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    led_tx_o == tx_en_o) else note_failure("led_tx_o differs from tx_en_o");
  led_run_follows: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    led_run_o == run_o) else note_failure("led_run_o differs from run_o");
  tx_needs_relay: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    !(tx_en_o && !pa_tr_o)) else note_failure("tx_en_o high while pa_tr_o is low");
  key_needs_run: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    $rose(pa_tr_o) |-> $past(run_o)) else note_failure("pa_tr_o rose while run was low");

  ////////////////////
  // model and helpers

  function automatic hpsdr_pkg::cmd_t random_cmd(input logic [5:0] addr, input logic mox);
    hpsdr_pkg::cmd_t c;
    c.addr = addr;
    c.mox  = mox;
    c.data = $urandom;
    return c;
  endfunction

  // accepted data packet and model update for frames with good sync
  task automatic send_cmds(input hpsdr_pkg::cmd_t cmd0, input hpsdr_pkg::cmd_t cmd1,
                           input int bad_frame);
    send_data_pkt(DATA_PORT, hpsdr_pkg::HDR_BYTE0, cmd0, cmd1, bad_frame);
    if (bad_frame != 0) exp_regs[cmd0.addr] = cmd0.data;
    if (bad_frame != 1) exp_regs[cmd1.addr] = cmd1.data;
  endtask

  task automatic check_regs();
    logic [3:0] exp_num_rx;
    for (int a = 0; a < 64; a++) begin
      rd_addr_i = 6'(a);
      @(negedge clk_ctrl);
      check_value($sformatf("readback addr %0d", a), exp_regs[a], rd_data_o);
    end
    // receiver field holds the count minus one
    exp_num_rx = exp_regs[hpsdr_pkg::ADDR_CONFIG][6:3] + 4'd1;
    check_value("cfg rate", 32'(exp_regs[hpsdr_pkg::ADDR_CONFIG][25:24]), 32'(cfg_o.rate));
    check_value("cfg num_rx", 32'(exp_num_rx), 32'(cfg_o.num_rx));
    check_value("cfg tx_drive", 32'(exp_regs[hpsdr_pkg::ADDR_TX_DRIVE][31:24]),
                32'(cfg_o.tx_drive));
  endtask

  task automatic wait_tr_outputs(input logic pa_exp, input logic tx_exp, input int max_cycles);
    int n;
    n = 0;
    while ((pa_tr_o !== pa_exp || tx_en_o !== tx_exp) && n < max_cycles) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (pa_tr_o !== pa_exp || tx_en_o !== tx_exp) begin
      note_failure($sformatf("T/R outputs did not reach pa_tr %0b tx_en %0b", pa_exp, tx_exp));
    end
    // one more falling edge so the edge monitor has logged the last change
    @(negedge clk_ctrl);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_ctrl);
    $display("timeout, test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////
  // test sequence

  initial begin
    logic [7:0] sync_before;
    int         rises_before;
    int         inhibit_cyc;
    void'($urandom(7));
    rst_i        = 1'b1;
    eth_valid_i  = 1'b0;
    eth_data_i   = '0;
    eth_port_i   = DATA_PORT;
    tx_inhibit_i = 1'b0;
    rd_addr_i    = '0;
    for (int a = 0; a < 64; a++) exp_regs[a] = '0;
    repeat (10) @(negedge clk_ctrl);
    rst_i = 1'b0;
    @(negedge clk_ctrl);

    // start/stop decode
    send_startstop(DATA_PORT, 8'h03);
    check_value("run rise cycle", ss_ctrl_cyc + 1, run_rise_cyc);
    check_value("run after start", 32'd1, 32'(run_o));
    check_value("wide spectrum after start", 32'd1, 32'(wide_spectrum_o));
    send_startstop(DATA_PORT, 8'h00);
    check_value("run after stop", 32'd0, 32'(run_o));
    check_value("wide spectrum after stop", 32'd0, 32'(wide_spectrum_o));

    // storage and decode
    send_cmds(random_cmd(hpsdr_pkg::ADDR_CONFIG, 1'b0),
              random_cmd(hpsdr_pkg::ADDR_TX_DRIVE, 1'b0), -1);
    send_cmds(random_cmd(6'($urandom), 1'b0), random_cmd(6'($urandom), 1'b0), -1);
    check_regs();

    // bad sync, foreign port, wrong preamble
    sync_before = sync_errors_o;
    send_cmds(random_cmd(hpsdr_pkg::ADDR_TX_DRIVE, 1'b0), random_cmd(6'($urandom), 1'b0), 0);
    check_value("sync errors after bad frame", 32'(sync_before + 8'd1), 32'(sync_errors_o));
    send_startstop(DATA_PORT + 16'd1, 8'h03);
    send_data_pkt(DATA_PORT + 16'd1, hpsdr_pkg::HDR_BYTE0,
                  random_cmd(6'($urandom), 1'b0), random_cmd(6'($urandom), 1'b0), -1);
    send_data_pkt(DATA_PORT, 8'hEE,
                  random_cmd(6'($urandom), 1'b0), random_cmd(6'($urandom), 1'b0), -1);
    check_value("run after ignored packets", 32'd0, 32'(run_o));
    check_value("sync errors after ignored packets", 32'(sync_before + 8'd1),
                32'(sync_errors_o));
    check_regs();

    // MOX while not running
    rises_before = pa_rises;
    send_cmds(random_cmd(6'($urandom), 1'b1), random_cmd(6'($urandom), 1'b1), -1);
    check_value("cfg mox after MOX command", 32'd1, 32'(cfg_o.mox));
    send_cmds(random_cmd(6'($urandom), 1'b0), random_cmd(6'($urandom), 1'b0), -1);
    check_value("pa_tr rises with run low", rises_before, pa_rises);

    // keying and release by MOX
    send_startstop(DATA_PORT, 8'h01);
    send_cmds(random_cmd(6'($urandom), 1'b1), random_cmd(6'($urandom), 1'b1), -1);
    wait_tr_outputs(1'b1, 1'b1, TR_DELAY + 10);
    check_value("pa_tr rise after C4", c4_cyc[0] + 3, pa_rise_cyc);
    check_value("tx_en rise after pa_tr", pa_rise_cyc + TR_DELAY, tx_rise_cyc);
    send_cmds(random_cmd(6'($urandom), 1'b0), random_cmd(6'($urandom), 1'b0), -1);
    wait_tr_outputs(1'b0, 1'b0, TR_HANG + 10);
    check_value("tx_en fall after MOX release", c4_cyc[0] + 3, tx_fall_cyc);
    check_value("pa_tr fall after MOX release", tx_fall_cyc + TR_HANG, pa_fall_cyc);

    // release by TX inhibit
    send_cmds(random_cmd(6'($urandom), 1'b1), random_cmd(6'($urandom), 1'b1), -1);
    wait_tr_outputs(1'b1, 1'b1, TR_DELAY + 10);
    inhibit_cyc  = cyc;
    tx_inhibit_i = 1'b1;
    wait_tr_outputs(1'b0, 1'b0, TR_HANG + 10);
    check_value("tx_en fall after inhibit", inhibit_cyc + 1, tx_fall_cyc);
    check_value("pa_tr fall after inhibit", tx_fall_cyc + TR_HANG, pa_fall_cyc);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+tb
logic/hpsdr_pkg.sv
logic/ds_packet_parser.sv
logic/cmd_regs.sv
logic/tr_sequencer.sv
logic/hpsdr_ds_ctrl.sv
tb/tb_hpsdr_ds_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the downstream control testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f \
  --top-module tb_hpsdr_ds_ctrl -o sim_tb \
  && ./obj_dir/sim_tb | tee "$log" \
  || { echo "build or simulation run failed"; exit 1; }

# the log decides pass or fail
grep -q "Done: errors found" "$log" \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
